// ==== all.f ====
design/board_ctrl_pkg.sv
design/spi_reg_slave.sv
design/ctrl_reg_bank.sv
design/board_pin_io.sv
design/board_ctrl_top.sv
verif/tb_clk_gen.sv
verif/tb_board_ctrl.sv

// ==== design/board_ctrl_pkg.sv ====
//----------------------------------------
// board control register map, widths,
// register word types and spi frame states
//----------------------------------------
package board_ctrl_pkg;

    //----------------------------------------
    // sizes
    //----------------------------------------
    localparam int SPI_ADDR_BITS    = 8;
    localparam int SPI_DATA_BITS    = 16;
    localparam int ETH_PORTS        = 4;
    localparam int ERR_WORDS        = 2 * ETH_PORTS;  // two words per counter
    localparam int TEST_ARRAY_COUNT = 8;

    //----------------------------------------
    // types
    //----------------------------------------
    typedef logic [SPI_DATA_BITS-1:0]         reg_word_t;
    typedef logic [SPI_ADDR_BITS-2:0]         reg_addr_t;  // top bit of addr byte is r/w
    typedef logic [31:0]                      err_cnt_t;
    typedef logic [ETH_PORTS-1:0]             link_t;
    typedef logic [31:0]                      fw_stamp_t;
    typedef logic [$clog2(SPI_DATA_BITS)-1:0] spi_bit_cnt_t;

    // one register write from the spi side
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        reg_word_t data;
    } reg_wr_t;

    // bit-banged mdio pins
    typedef struct packed {
        logic mdc;
        logic data;
        logic dir;   // 1 = fpga drives mdio
    } mdio_ctrl_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } spi_phase_e;

    // constant firmware type word
    localparam reg_word_t FW_TYPE = 16'h0003;

    //----------------------------------------
    // register map
    //----------------------------------------
    // read only
    localparam reg_addr_t RA_FW_DATE    = 7'd0;   // 2 words
    localparam reg_addr_t RA_FW_TIME    = 7'd2;   // 2 words
    localparam reg_addr_t RA_FW_TYPE    = 7'd4;
    localparam reg_addr_t RA_MAC_LINK   = 7'd5;
    localparam reg_addr_t RA_RXERR0     = 7'd6;   // port n at 6+2n
    // read/write
    localparam reg_addr_t RA_PHY_RST    = 7'd16;
    localparam reg_addr_t RA_MDIO_CLK   = 7'd17;
    localparam reg_addr_t RA_MDIO_DATA  = 7'd18;
    localparam reg_addr_t RA_MDIO_DIR   = 7'd19;
    // read only mdio pin level
    localparam reg_addr_t RA_MDIO_IN    = 7'd20;
    // scratch words, 32 to 39
    localparam reg_addr_t RA_TEST_ARRAY = 7'd32;

endpackage

// ==== design/board_ctrl_top.sv ====
//----------------------------------------
// board control top level
//----------------------------------------
module board_ctrl_top import board_ctrl_pkg::*; (
    input  logic                     clk125M,
    input  logic                     reset_i,
    input  logic                     spi_clk_i,
    input  logic [1:0]               spi_cs_n_i,
    input  logic                     spi_mosi_i,
    input  logic                     qspi_miso_i,
    input  logic                     mdio_i,
    input  fw_stamp_t                fw_date_i,
    input  fw_stamp_t                fw_time_i,
    input  err_cnt_t [ETH_PORTS-1:0] rxerr_cnt_i,
    input  link_t                    mac_link_i,
    output logic                     spi_miso_o,
    output logic                     qspi_cs_n_o,
    output logic                     qspi_mosi_o,
    output logic                     mdio_o,
    output logic                     mdio_oe_o,
    output logic                     eth_phy_mdc_o,
    output link_t                    eth_phy_rst_o,
    output link_t                    lvds_status_o
);

    reg_wr_t    reg_wr;
    reg_addr_t  rd_addr;
    reg_word_t  rd_data;
    logic       spi_miso;      // register slave miso before sharing
    link_t      link_sync;
    logic       mdio_in_sync;
    mdio_ctrl_t mdio_ctrl;

    // register slave sits on chip select 1
    spi_reg_slave spi0 (
        .clk125M    (clk125M),
        .reset_i    (reset_i),
        .spi_clk_i  (spi_clk_i),
        .spi_cs_n_i (spi_cs_n_i[1]),
        .spi_mosi_i (spi_mosi_i),
        .rd_data_i  (rd_data),
        .reg_wr_o   (reg_wr),
        .rd_addr_o  (rd_addr),
        .spi_miso_o (spi_miso)
    );

    ctrl_reg_bank regs0 (
        .clk125M     (clk125M),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr),
        .rd_addr_i   (rd_addr),
        .fw_date_i   (fw_date_i),
        .fw_time_i   (fw_time_i),
        .rxerr_cnt_i (rxerr_cnt_i),
        .link_i      (link_sync),
        .mdio_in_i   (mdio_in_sync),
        .rd_data_o   (rd_data),
        .mdio_ctrl_o (mdio_ctrl),
        .phy_rst_o   (eth_phy_rst_o)
    );

    board_pin_io pins0 (
        .clk125M        (clk125M),
        .reset_i        (reset_i),
        .mac_link_i     (mac_link_i),
        .mdio_i         (mdio_i),
        .spi_cs_n_i     (spi_cs_n_i),
        .spi_mosi_i     (spi_mosi_i),
        .qspi_miso_i    (qspi_miso_i),
        .reg_miso_i     (spi_miso),
        .mdio_ctrl_i    (mdio_ctrl),
        .link_sync_o    (link_sync),
        .mdio_in_sync_o (mdio_in_sync),
        .spi_miso_o     (spi_miso_o),
        .qspi_cs_n_o    (qspi_cs_n_o),
        .qspi_mosi_o    (qspi_mosi_o),
        .mdio_o         (mdio_o),
        .mdio_oe_o      (mdio_oe_o),
        .eth_phy_mdc_o  (eth_phy_mdc_o),
        .lvds_status_o  (lvds_status_o)
    );

endmodule

// ==== design/board_pin_io.sv ====
//----------------------------------------
// board pins: input sync, miso sharing,
// mdio split and lvds link status
//----------------------------------------
module board_pin_io import board_ctrl_pkg::*; (
    input  logic       clk125M,
    input  logic       reset_i,
    input  link_t      mac_link_i,
    input  logic       mdio_i,
    input  logic [1:0] spi_cs_n_i,   // [0] flash, [1] register slave
    input  logic       spi_mosi_i,
    input  logic       qspi_miso_i,
    input  logic       reg_miso_i,
    input  mdio_ctrl_t mdio_ctrl_i,
    output link_t      link_sync_o,
    output logic       mdio_in_sync_o,
    output logic       spi_miso_o,
    output logic       qspi_cs_n_o,
    output logic       qspi_mosi_o,
    output logic       mdio_o,
    output logic       mdio_oe_o,
    output logic       eth_phy_mdc_o,
    output link_t      lvds_status_o
);

    link_t link_meta;
    logic  mdio_meta;

    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            link_meta      <= '0;
            link_sync_o    <= '0;
            mdio_meta      <= 1'b0;
            mdio_in_sync_o <= 1'b0;
            lvds_status_o  <= '0;
        end else begin
            link_meta      <= mac_link_i;
            link_sync_o    <= link_meta;
            mdio_meta      <= mdio_i;
            mdio_in_sync_o <= mdio_meta;
            lvds_status_o  <= link_sync_o;  // 3 cycles from pin
        end
    end

    // deselected source floats high, so AND picks the active one
    assign spi_miso_o    = (qspi_miso_i | spi_cs_n_i[0]) & (reg_miso_i | spi_cs_n_i[1]);
    assign qspi_cs_n_o   = spi_cs_n_i[0];
    assign qspi_mosi_o   = spi_mosi_i;

    assign mdio_oe_o     = mdio_ctrl_i.dir;
    assign mdio_o        = mdio_ctrl_i.dir & mdio_ctrl_i.data;
    assign eth_phy_mdc_o = mdio_ctrl_i.mdc;

endmodule

// ==== design/ctrl_reg_bank.sv ====
//----------------------------------------
// control register bank
// writable regs and registered read mux
//----------------------------------------
module ctrl_reg_bank import board_ctrl_pkg::*; (
    input  logic                     clk125M,
    input  logic                     reset_i,
    input  reg_wr_t                  reg_wr_i,
    input  reg_addr_t                rd_addr_i,
    input  fw_stamp_t                fw_date_i,
    input  fw_stamp_t                fw_time_i,
    input  err_cnt_t [ETH_PORTS-1:0] rxerr_cnt_i,
    input  link_t                    link_i,
    input  logic                     mdio_in_i,
    output reg_word_t                rd_data_o,
    output mdio_ctrl_t               mdio_ctrl_o,
    output link_t                    phy_rst_o
);

    reg_word_t [TEST_ARRAY_COUNT-1:0] test_array;
    reg_word_t [ERR_WORDS-1:0]        err_words;   // low half first
    reg_addr_t                        wr_ta_off;
    reg_addr_t                        rd_ta_off;
    reg_addr_t                        rd_err_off;
    reg_word_t                        rd_word;

    assign err_words  = rxerr_cnt_i;
    // offsets wrap to large values below the base
    assign wr_ta_off  = reg_wr_i.addr - RA_TEST_ARRAY;
    assign rd_ta_off  = rd_addr_i - RA_TEST_ARRAY;
    assign rd_err_off = rd_addr_i - RA_RXERR0;

    //----------------------------------------
    // write decode
    //----------------------------------------
    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            test_array  <= '0;
            phy_rst_o   <= '0;
            mdio_ctrl_o <= '0;  // dir 0, mdio released
        end else if (reg_wr_i.en) begin
            case (reg_wr_i.addr)
                RA_PHY_RST:   phy_rst_o        <= reg_wr_i.data[ETH_PORTS-1:0];
                RA_MDIO_CLK:  mdio_ctrl_o.mdc  <= reg_wr_i.data[0];
                RA_MDIO_DATA: mdio_ctrl_o.data <= reg_wr_i.data[0];
                RA_MDIO_DIR:  mdio_ctrl_o.dir  <= reg_wr_i.data[0];
                default: begin
                    // read-only and unmapped addresses fall through here
                    if (wr_ta_off < TEST_ARRAY_COUNT) begin
                        test_array[wr_ta_off] <= reg_wr_i.data;
                    end
                end
            endcase
        end
    end

    //----------------------------------------
    // read mux
    //----------------------------------------
    always_comb begin
        rd_word = '0;  // unmapped reads 0
        case (rd_addr_i)
            RA_FW_DATE:     rd_word = fw_date_i[15:0];
            RA_FW_DATE + 1: rd_word = fw_date_i[31:16];
            RA_FW_TIME:     rd_word = fw_time_i[15:0];
            RA_FW_TIME + 1: rd_word = fw_time_i[31:16];
            RA_FW_TYPE:     rd_word = FW_TYPE;
            RA_MAC_LINK:    rd_word = reg_word_t'(link_i);
            RA_PHY_RST:     rd_word = reg_word_t'(phy_rst_o);
            RA_MDIO_CLK:    rd_word = reg_word_t'(mdio_ctrl_o.mdc);
            RA_MDIO_DATA:   rd_word = reg_word_t'(mdio_ctrl_o.data);
            RA_MDIO_DIR:    rd_word = reg_word_t'(mdio_ctrl_o.dir);
            RA_MDIO_IN:     rd_word = reg_word_t'(mdio_in_i);
            default: begin
                if (rd_err_off < ERR_WORDS) begin
                    rd_word = err_words[rd_err_off];  // 2 words per port
                end else if (rd_ta_off < TEST_ARRAY_COUNT) begin
                    rd_word = test_array[rd_ta_off];
                end
            end
        endcase
    end

    // one cycle behind rd_addr_i
    always_ff @(posedge clk125M) begin
        rd_data_o <= rd_word;
    end

endmodule

// ==== design/spi_reg_slave.sv ====
//----------------------------------------
// spi register slave, mode 0, msb first
// addr byte + 16-bit word per frame
//----------------------------------------
module spi_reg_slave import board_ctrl_pkg::*; (
    input  logic      clk125M,
    input  logic      reset_i,
    input  logic      spi_clk_i,
    input  logic      spi_cs_n_i,
    input  logic      spi_mosi_i,
    input  reg_word_t rd_data_i,
    output reg_wr_t   reg_wr_o,
    output reg_addr_t rd_addr_o,
    output logic      spi_miso_o
);

    logic [2:0]   sclk_sync;   // two sync stages + edge history
    logic [2:0]   cs_sync;
    logic [1:0]   mosi_sync;
    logic         sclk_rise;
    logic         sclk_fall;
    logic         cs_fall;
    logic         cs_high;
    logic         mosi_bit;
    logic         addr_done;
    logic         data_done;

    spi_phase_e   phase;
    spi_bit_cnt_t bit_cnt;
    logic         rd_frame;    // bit 7 of the addr byte
    logic         wr_en;
    reg_word_t    wr_data;
    reg_word_t    rx_shift;
    reg_word_t    tx_shift;

    //----------------------------------------
    // pin synchronizers
    //----------------------------------------
    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            sclk_sync <= '0;
            cs_sync   <= '1;  // deselected
        end else begin
            sclk_sync <= {sclk_sync[1:0], spi_clk_i};
            cs_sync   <= {cs_sync[1:0], spi_cs_n_i};
        end
    end

    always_ff @(posedge clk125M) begin
        mosi_sync <= {mosi_sync[0], spi_mosi_i};
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign cs_fall   = ~cs_sync[1] & cs_sync[2];
    assign cs_high   = cs_sync[1];
    assign mosi_bit  = mosi_sync[1];  // same depth as sclk_sync[1]

    assign addr_done = (phase == ADDR) && sclk_rise
                       && (bit_cnt == spi_bit_cnt_t'(SPI_ADDR_BITS - 1));
    assign data_done = (phase == DATA) && sclk_rise
                       && (bit_cnt == spi_bit_cnt_t'(SPI_DATA_BITS - 1));

    //----------------------------------------
    // frame fsm
    //----------------------------------------
    always_ff @(posedge clk125M) begin
        if (reset_i) begin
            phase    <= IDLE;
            bit_cnt  <= '0;
            rd_frame <= 1'b0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (cs_high) begin
                phase <= IDLE;  // early cs rise drops the frame
            end else begin
                case (phase)
                    IDLE: begin
                        if (cs_fall) begin
                            phase   <= ADDR;
                            bit_cnt <= '0;
                        end
                    end
                    ADDR: begin
                        if (addr_done) begin
                            phase    <= DATA;
                            bit_cnt  <= '0;
                            rd_frame <= rx_shift[SPI_ADDR_BITS-2];
                        end else if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    DATA: begin
                        if (data_done) begin
                            phase <= IDLE;  // waits for next cs fall
                            wr_en <= ~rd_frame;
                        end else if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: phase <= IDLE;
                endcase
            end
        end
    end

    // shift registers and captured frame fields
    always_ff @(posedge clk125M) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[SPI_DATA_BITS-2:0], mosi_bit};
        end
        if (addr_done) begin
            rd_addr_o <= {rx_shift[SPI_ADDR_BITS-3:0], mosi_bit};
        end
        if (data_done) begin
            wr_data <= {rx_shift[SPI_DATA_BITS-2:0], mosi_bit};
        end
        if (cs_high) begin
            tx_shift <= '0;
        end else if ((phase == DATA) && sclk_fall) begin
            // first falling edge after the addr byte loads the read word
            if (bit_cnt == '0) begin
                tx_shift <= rd_frame ? rd_data_i : '0;
            end else begin
                tx_shift <= {tx_shift[SPI_DATA_BITS-2:0], 1'b0};
            end
        end
    end

    assign spi_miso_o = tx_shift[SPI_DATA_BITS-1];
    assign reg_wr_o   = '{en: wr_en, addr: rd_addr_o, data: wr_data};

endmodule

// ==== verif/tb_board_ctrl.sv ====
//----------------------------------------
// board control testbench: spi host tasks,
// register map model and checks
//----------------------------------------
module tb_board_ctrl import board_ctrl_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_BIT       = 8;      // clk125M cycles per spi half period
    localparam int TIMEOUT_CYCLES = 30000;

    logic clk125M, reset_i, spi_clk_i, spi_mosi_i, qspi_miso_i, mdio_i;
    logic [1:0] spi_cs_n_i;
    fw_stamp_t fw_date_i, fw_time_i;
    err_cnt_t [ETH_PORTS-1:0] rxerr_cnt_i;
    link_t mac_link_i, eth_phy_rst_o, lvds_status_o;
    logic spi_miso_o, qspi_cs_n_o, qspi_mosi_o, mdio_o, mdio_oe_o, eth_phy_mdc_o;

    // reference model of the writable registers
    reg_word_t test_m [TEST_ARRAY_COUNT];
    link_t     phy_rst_m;
    logic      mdc_m, data_m, dir_m;

    int errors, checks, tests_run, tests_failed, err_mark, chk_mark;
    int cycle_cnt, since_reset, i;
    link_t [2:0] link_hist;
    reg_word_t wdat;
    int unsigned seed_dummy;

    tb_clk_gen clk_gen0 (.clk_o(clk125M), .reset_o(reset_i));

    board_ctrl_top dut0 (.*);

    //----------------------------------------
    // checks and model
    //----------------------------------------
    task automatic check_word(input string name, input logic [31:0] got_v,
                              input logic [31:0] exp_v);
        checks++;
        assert (got_v === exp_v)
        else begin
            errors++;
            $display("MISMATCH time=%0t %s: expected 0x%0h, got 0x%0h",
                     $time, name, exp_v, got_v);
        end
    endtask

    function automatic void model_write(input reg_addr_t addr, input reg_word_t data);
        int a;
        a = int'(addr);
        if (a == RA_PHY_RST) phy_rst_m = data[ETH_PORTS-1:0];
        else if (a == RA_MDIO_CLK) mdc_m = data[0];
        else if (a == RA_MDIO_DATA) data_m = data[0];
        else if (a == RA_MDIO_DIR) dir_m = data[0];
        else if (a >= RA_TEST_ARRAY && a < RA_TEST_ARRAY + TEST_ARRAY_COUNT)
            test_m[a - RA_TEST_ARRAY] = data;
        // anything else is read only or unmapped
    endfunction

    function automatic reg_word_t expected_word(input reg_addr_t addr);
        int a;
        int r;
        a = int'(addr);
        r = a - RA_RXERR0;
        if (a >= RA_FW_DATE && a < RA_FW_DATE + 2)
            return reg_word_t'(fw_date_i >> (16 * (a - RA_FW_DATE)));
        if (a >= RA_FW_TIME && a < RA_FW_TIME + 2)
            return reg_word_t'(fw_time_i >> (16 * (a - RA_FW_TIME)));
        if (a == RA_FW_TYPE) return FW_TYPE;
        if (a == RA_MAC_LINK) return reg_word_t'(mac_link_i);
        if (r >= 0 && r < 2 * ETH_PORTS)
            return reg_word_t'(rxerr_cnt_i[r / 2] >> (16 * (r % 2)));  // low half first
        if (a == RA_PHY_RST) return reg_word_t'(phy_rst_m);
        if (a == RA_MDIO_CLK) return reg_word_t'(mdc_m);
        if (a == RA_MDIO_DATA) return reg_word_t'(data_m);
        if (a == RA_MDIO_DIR) return reg_word_t'(dir_m);
        if (a == RA_MDIO_IN) return reg_word_t'(mdio_i);
        if (a >= RA_TEST_ARRAY && a < RA_TEST_ARRAY + TEST_ARRAY_COUNT)
            return test_m[a - RA_TEST_ARRAY];
        return '0;
    endfunction

    //----------------------------------------
    // spi host, mode 0
    //----------------------------------------
    task automatic spi_bit(input logic mosi, output logic miso);
        @(posedge clk125M);
        spi_clk_i  <= 1'b0;
        spi_mosi_i <= mosi;
        repeat (HALF_BIT - 1) @(posedge clk125M);
        @(negedge clk125M);
        miso = spi_miso_o;  // value seen at the coming rising edge
        @(posedge clk125M);
        spi_clk_i <= 1'b1;
        repeat (HALF_BIT - 1) @(posedge clk125M);
    endtask

    task automatic run_frame(input logic [7:0] addr_byte, input reg_word_t wdata,
                             output reg_word_t rdata);
        logic [23:0] frame;
        logic miso;
        int b;
        frame = {addr_byte, wdata};
        rdata = '0;
        @(posedge clk125M);
        spi_cs_n_i <= 2'b01;  // register slave selected, flash not
        repeat (4) @(posedge clk125M);
        for (b = 23; b >= 0; b--) begin
            spi_bit(frame[b], miso);
            if (b < 16) rdata[b] = miso;
        end
        @(posedge clk125M);
        spi_clk_i  <= 1'b0;
        spi_cs_n_i <= 2'b11;
        repeat (HALF_BIT) @(posedge clk125M);  // gap between frames
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
        reg_word_t unused;
        run_frame({1'b0, addr}, data, unused);
        model_write(addr, data);
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
        run_frame({1'b1, addr}, '0, data);
    endtask

    task automatic check_read(input reg_addr_t addr);
        reg_word_t rd;
        read_reg(addr, rd);
        check_word($sformatf("spi_miso_o word at addr %0d", addr), rd, expected_word(addr));
    endtask

    task automatic start_test();
        err_mark = errors;
        chk_mark = checks;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed, %0d checks", name, checks - chk_mark);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - err_mark);
        end
    endtask

    //----------------------------------------
    // lvds status monitor and timeout
    //----------------------------------------
    always @(negedge clk125M) begin
        if (reset_i) begin
            since_reset = 0;
        end else begin
            if (since_reset >= 4) check_word("lvds_status_o", lvds_status_o, link_hist[2]);
            since_reset++;
        end
        link_hist = {link_hist[1:0], mac_link_i};  // [2] is 3 cycles old
    end

    always @(posedge clk125M) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //----------------------------------------
    // test sequence
    //----------------------------------------
    initial begin
        spi_clk_i = 1'b0;
        spi_cs_n_i = 2'b11;
        spi_mosi_i = 1'b0;
        qspi_miso_i = 1'b1;
        mdio_i = 1'b0;
        fw_date_i = '0;
        fw_time_i = '0;
        rxerr_cnt_i = '0;
        mac_link_i = '0;
        for (i = 0; i < TEST_ARRAY_COUNT; i++) test_m[i] = '0;
        phy_rst_m = '0;
        {mdc_m, data_m, dir_m} = '0;
        {errors, checks, tests_run, tests_failed, cycle_cnt, since_reset} = '0;
        link_hist = '0;
        seed_dummy = $urandom(56);
        wait (reset_i == 1'b0);
        repeat (4) @(posedge clk125M);

        start_test();
        @(negedge clk125M);
        check_word("eth_phy_rst_o", eth_phy_rst_o, 0);
        check_word("eth_phy_mdc_o", eth_phy_mdc_o, 0);
        check_word("mdio_oe_o", mdio_oe_o, 0);
        check_word("lvds_status_o", lvds_status_o, 0);
        for (i = 0; i < TEST_ARRAY_COUNT; i++) check_read(RA_TEST_ARRAY + i);
        finish_test("reset state");

        start_test();
        for (i = 0; i < TEST_ARRAY_COUNT; i++) write_reg(RA_TEST_ARRAY + i, $urandom());
        for (i = 0; i < TEST_ARRAY_COUNT; i++) check_read(RA_TEST_ARRAY + i);
        write_reg(RA_FW_TYPE, $urandom());  // read only, model keeps FW_TYPE
        check_read(RA_FW_TYPE);
        finish_test("test array");

        start_test();
        @(posedge clk125M);
        fw_date_i  <= $urandom();
        fw_time_i  <= $urandom();
        mac_link_i <= $urandom();
        for (i = 0; i < ETH_PORTS; i++) rxerr_cnt_i[i] <= $urandom();
        for (i = 0; i < RA_RXERR0 + 2 * ETH_PORTS; i++) check_read(i);
        check_read(7'd21);   // unmapped
        check_read(7'd100);
        finish_test("read-only words");

        start_test();
        wdat = $urandom();
        write_reg(RA_PHY_RST, wdat);
        write_reg(RA_MDIO_CLK, 16'h0001);
        write_reg(RA_MDIO_DATA, 16'h0001);
        write_reg(RA_MDIO_DIR, 16'h0001);
        @(negedge clk125M);
        check_word("eth_phy_rst_o", eth_phy_rst_o, phy_rst_m);
        check_word("eth_phy_mdc_o", eth_phy_mdc_o, mdc_m);
        check_word("mdio_o", mdio_o, data_m);
        check_word("mdio_oe_o", mdio_oe_o, dir_m);
        for (i = RA_PHY_RST; i <= RA_MDIO_DIR; i++) check_read(i);
        write_reg(RA_MDIO_DATA, 16'h0000);  // fpga still drives the pin
        @(negedge clk125M);
        check_word("mdio_o", mdio_o, data_m);
        write_reg(RA_MDIO_DIR, 16'h0000);
        @(negedge clk125M);
        check_word("mdio_oe_o", mdio_oe_o, 0);
        @(posedge clk125M);
        mdio_i <= 1'b1;
        check_read(RA_MDIO_IN);
        @(posedge clk125M);
        mdio_i <= 1'b0;
        check_read(RA_MDIO_IN);
        finish_test("phy management");

        start_test();
        for (i = 0; i < 16; i++) begin
            @(posedge clk125M);
            spi_cs_n_i  <= 2'b10;  // flash selected
            qspi_miso_i <= $urandom();
            spi_mosi_i  <= $urandom();
            @(negedge clk125M);
            check_word("spi_miso_o", spi_miso_o, qspi_miso_i);
            check_word("qspi_cs_n_o", qspi_cs_n_o, spi_cs_n_i[0]);
            check_word("qspi_mosi_o", qspi_mosi_o, spi_mosi_i);
        end
        @(posedge clk125M);
        spi_cs_n_i <= 2'b11;
        @(negedge clk125M);
        check_word("qspi_cs_n_o", qspi_cs_n_o, 1);
        finish_test("flash sharing");

        start_test();
        for (i = 0; i < 40; i++) begin
            @(posedge clk125M);
            mac_link_i <= $urandom();
        end
        repeat (6) @(posedge clk125M);  // let the monitor see the last values
        finish_test("link status");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
//----------------------------------------
// testbench clock and reset source
//----------------------------------------
module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;  // 8 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (8) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule
